/* design/branch_jump_unit.sv */
////////////////////////////////////////////////////////////
// Branch resolution and jump target. Gives branch_taken
// and the next fetch address: jump target, branch target
// or the sequential pc. Combinational.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module branch_jump_unit (
    input  exec_pkg::uop_t  ex_in,
    input  exec_pkg::word_t rs1_val,
    input  exec_pkg::word_t rs2_val,
    output logic            branch_taken,
    output exec_pkg::word_t brj_addr
);

    exec_pkg::word_t imm_i_ext;
    exec_pkg::word_t imm_sb_ext;
    exec_pkg::word_t imm_uj_ext;
    exec_pkg::word_t jump_addr;
    logic            cond;

    assign imm_i_ext  = {{20{ex_in.imm_i[11]}}, ex_in.imm_i};
    assign imm_sb_ext = {{19{ex_in.imm_sb[12]}}, ex_in.imm_sb};
    assign imm_uj_ext = {{11{ex_in.imm_uj[20]}}, ex_in.imm_uj};

    always_comb begin
        case (ex_in.branch_type)
            exec_pkg::BEQ:  cond = (rs1_val == rs2_val);
            exec_pkg::BNE:  cond = (rs1_val != rs2_val);
            exec_pkg::BLT:  cond = ($signed(rs1_val) < $signed(rs2_val));
            exec_pkg::BGE:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            exec_pkg::BLTU: cond = (rs1_val < rs2_val);
            exec_pkg::BGEU: cond = (rs1_val >= rs2_val);
            default:        cond = 1'b0;
        endcase
    end

    // compare result only counts for branch uops
    assign branch_taken = ex_in.branch && cond;

    // jal is pc relative, jalr is register relative
    assign jump_addr = ex_in.j_sel ? ex_in.pc + imm_uj_ext : rs1_val + imm_i_ext;

    assign brj_addr = ex_in.jump     ? jump_addr :
                      branch_taken   ? ex_in.pc + imm_sb_ext :
                      ex_in.pc + exec_pkg::word_t'(exec_pkg::PC_STEP);

endmodule

`default_nettype wire

/* design/ex_mem_register.sv */
////////////////////////////////////////////////////////////
// Execute/memory pipeline register. Selects the result,
// holds on stall, clears on flush and squashes control
// bits of an illegal uop. advance tells the muldiv
// sequencer that a new value is taken at the next edge.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_mem_register (
    input  logic              CLK,
    input  logic              nRST,
    input  exec_pkg::uop_t    ex_in,
    input  exec_pkg::word_t   rs2_val,
    input  exec_pkg::word_t   alu_out,
    input  exec_pkg::word_t   muldiv_out,
    input  logic              branch_taken,
    input  exec_pkg::word_t   brj_addr,
    input  logic              stall,
    input  logic              flush,
    output exec_pkg::ex_mem_t ex_mem,
    output logic              advance
);

    exec_pkg::word_t result;

    assign result  = ex_in.muldiv_sel ? muldiv_out : alu_out;
    assign advance = !stall && !flush;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_mem <= '0;
        end else if (!stall) begin
            // stall beats flush
            if (flush) begin
                ex_mem <= '0;
            end else begin
                ex_mem.valid        <= ex_in.valid;
                ex_mem.illegal      <= ex_in.illegal;
                // side effects squashed on illegal
                ex_mem.reg_write    <= ex_in.reg_write && !ex_in.illegal;
                ex_mem.dren         <= ex_in.dren && !ex_in.illegal;
                ex_mem.dwen         <= ex_in.dwen && !ex_in.illegal;
                ex_mem.branch_taken <= branch_taken && !ex_in.illegal;
                ex_mem.jump         <= ex_in.jump && !ex_in.illegal;
                ex_mem.rd           <= ex_in.rd;
                ex_mem.result       <= result;
                ex_mem.store_data   <= rs2_val;
                ex_mem.brj_addr     <= brj_addr;
                ex_mem.pc           <= ex_in.pc;
            end
        end
    end

    a_flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
        (flush && !stall) |=> !ex_mem.valid);

endmodule

`default_nettype wire

/* design/exec_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types and constants for the RV32 execute stage.
// Holds the word widths, control enums, micro-op and
// pipeline register structs. Design and testbench refer
// to these by scoped names.
////////////////////////////////////////////////////////////
`default_nettype none

package exec_pkg;

    // multiply/divide iteration count, one bit per step
    localparam int MULDIV_STEPS = 32;
    // one extra bit so an overrun would be visible
    localparam int MULDIV_CNT_W = $clog2(MULDIV_STEPS) + 1;
    // sequential pc increment
    localparam int PC_STEP = 4;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] imm12_t;
    typedef logic [12:0] imm13_t;
    typedef logic [20:0] imm21_t;
    typedef logic [MULDIV_CNT_W-1:0] muldiv_cnt_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
    } alu_op_t;

    typedef enum logic [1:0] {A_RS1, A_IMM_S, A_PC, A_ZERO} alu_a_sel_t;
    typedef enum logic [1:0] {B_RS1, B_RS2, B_IMM_I, B_IMM_U} alu_b_sel_t;

    // same encoding as funct3 of the branch opcode
    typedef enum logic [2:0] {
        BEQ = 3'd0, BNE = 3'd1, BLT = 3'd4, BGE = 3'd5, BLTU = 3'd6, BGEU = 3'd7
    } branch_t;

    typedef enum logic [1:0] {MUL, MULHU, DIVU, REMU} muldiv_op_t;
    typedef enum logic [1:0] {IDLE, BUSY, DONE} muldiv_state_t;

    // memory stage value and per-operand forward flags
    typedef struct packed {
        logic  fwd_rs1;
        logic  fwd_rs2;
        word_t rd_mem_data;
    } fwd_t;

    // decoded micro-op, operands already read
    typedef struct packed {
        logic       valid;
        logic       illegal;
        word_t      pc;
        word_t      rs1_data;
        word_t      rs2_data;
        imm12_t     imm_i;
        imm12_t     imm_s;
        imm13_t     imm_sb;
        imm21_t     imm_uj;
        // low 12 bits are zero
        word_t      imm_u;
        alu_op_t    alu_op;
        alu_a_sel_t alu_a_sel;
        alu_b_sel_t alu_b_sel;
        logic       branch;
        branch_t    branch_type;
        logic       jump;
        // 1 for jal, 0 for jalr
        logic       j_sel;
        logic       muldiv_sel;
        muldiv_op_t muldiv_op;
        reg_idx_t   rd;
        logic       reg_write;
        logic       dren;
        logic       dwen;
    } uop_t;

    typedef struct packed {
        logic     valid;
        logic     illegal;
        logic     reg_write;
        logic     dren;
        logic     dwen;
        logic     branch_taken;
        logic     jump;
        reg_idx_t rd;
        word_t    result;
        word_t    store_data;
        word_t    brj_addr;
        word_t    pc;
    } ex_mem_t;

endpackage

`default_nettype wire

/* design/execute_stage.sv */
////////////////////////////////////////////////////////////
// Execute stage top level. Takes one micro-op per cycle,
// computes ALU, branch and multiply/divide results and
// registers them for the memory stage. ex_busy goes to
// the hazard unit, which answers with stall and flush.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic             CLK,
    input  logic             nRST,
    input  exec_pkg::uop_t   ex_in,
    input  exec_pkg::fwd_t   fwd,
    input  logic             ex_mem_stall,
    input  logic             ex_mem_flush,
    output exec_pkg::ex_mem_t ex_mem,
    output logic             ex_busy
);

    // operands after forwarding
    exec_pkg::word_t rs1_val;
    exec_pkg::word_t rs2_val;
    exec_pkg::word_t alu_out;
    exec_pkg::word_t brj_addr;
    exec_pkg::word_t muldiv_out;
    logic            branch_taken;
    // muldiv control
    logic            md_load;
    logic            md_step;
    logic            last_step;
    logic            advance;

    operand_alu u_operand_alu (.ex_in, .fwd, .rs1_val, .rs2_val, .alu_out);

    branch_jump_unit u_branch_jump (.ex_in, .rs1_val, .rs2_val, .branch_taken, .brj_addr);

    muldiv_fsm u_muldiv_fsm (
        .CLK, .nRST,
        .start(ex_in.muldiv_sel), .last_step, .advance,
        .load(md_load), .step(md_step), .busy(ex_busy)
    );

    // counter restarts with each new operation
    muldiv_counter u_muldiv_counter (.CLK, .nRST, .clear(md_load), .step(md_step), .last_step);

    muldiv_datapath u_muldiv_datapath (
        .CLK, .nRST, .load(md_load), .step(md_step),
        .op(ex_in.muldiv_op), .a(rs1_val), .b(rs2_val), .muldiv_out
    );

    ex_mem_register u_ex_mem_register (
        .CLK, .nRST, .ex_in, .rs2_val, .alu_out, .muldiv_out,
        .branch_taken, .brj_addr,
        .stall(ex_mem_stall), .flush(ex_mem_flush),
        .ex_mem, .advance
    );

endmodule

`default_nettype wire

/* design/muldiv_counter.sv */
////////////////////////////////////////////////////////////
// Step counter for the multiply/divide unit. Counts from
// zero while step is high and flags the final step.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module muldiv_counter (
    input  logic CLK,
    input  logic nRST,
    input  logic clear,
    input  logic step,
    output logic last_step
);

    exec_pkg::muldiv_cnt_t count;

    // step number MULDIV_STEPS is count value MULDIV_STEPS-1
    assign last_step = step &&
        (count == exec_pkg::muldiv_cnt_t'(exec_pkg::MULDIV_STEPS - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (clear || last_step) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // a new operation always finds the count at zero
    a_count_range: assert property (@(posedge CLK) disable iff (!nRST)
        clear |-> (count == '0));

endmodule

`default_nettype wire

/* design/muldiv_datapath.sv */
////////////////////////////////////////////////////////////
// Unsigned multiply/divide datapath. One 64-bit register
// serves as product for a shift-add multiply, and as
// remainder:quotient for a restoring divide. Steered by
// load and step from the sequencer.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module muldiv_datapath (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 load,
    input  logic                 step,
    input  exec_pkg::muldiv_op_t op,
    input  exec_pkg::word_t      a,
    input  exec_pkg::word_t      b,
    output exec_pkg::word_t      muldiv_out
);

    exec_pkg::muldiv_op_t op_q;
    exec_pkg::word_t      b_q;
    // upper half product high or remainder, lower half multiplier or quotient
    exec_pkg::dword_t     acc;
    logic                 is_div;
    // multiply partial sum with carry
    logic [32:0]          sum;
    // remainder shifted left with next dividend bit
    logic [32:0]          shifted;

    assign is_div  = (op_q == exec_pkg::DIVU) || (op_q == exec_pkg::REMU);
    assign sum     = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, b_q} : 33'd0);
    assign shifted = {acc[63:32], acc[31]};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            op_q <= exec_pkg::MUL;
        end else if (load) begin
            op_q <= op;
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            b_q <= b;
            acc <= {32'b0, a};
        end else if (step) begin
            if (!is_div) begin
                // add multiplicand on low bit, shift right
                acc <= {sum, acc[31:1]};
            end else if (shifted >= {1'b0, b_q}) begin
                // difference fits, quotient bit 1
                acc <= {shifted[31:0] - b_q, acc[30:0], 1'b1};
            end else begin
                acc <= {shifted[31:0], acc[30:0], 1'b0};
            end
        end
    end

    // zero divisor leaves all ones and the dividend as remainder
    always_comb begin
        case (op_q)
            exec_pkg::MUL:   muldiv_out = acc[31:0];
            exec_pkg::MULHU: muldiv_out = acc[63:32];
            exec_pkg::DIVU:  muldiv_out = acc[31:0];
            default:         muldiv_out = acc[63:32];
        endcase
    end

endmodule

`default_nettype wire

/* design/muldiv_fsm.sv */
////////////////////////////////////////////////////////////
// Sequencer for the multiply/divide unit. Loads operands
// on start, steps the datapath until the counter reports
// the last step, then holds the result until the pipeline
// register advances. busy feeds the hazard unit.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module muldiv_fsm (
    input  logic CLK,
    input  logic nRST,
    input  logic start,
    input  logic last_step,
    input  logic advance,
    output logic load,
    output logic step,
    output logic busy
);

    exec_pkg::muldiv_state_t state, next_state;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= exec_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            exec_pkg::IDLE: if (start) next_state = exec_pkg::BUSY;
            exec_pkg::BUSY: if (last_step) next_state = exec_pkg::DONE;
            // result waits here until the register takes it
            exec_pkg::DONE: if (advance) next_state = exec_pkg::IDLE;
            default:        next_state = exec_pkg::IDLE;
        endcase
    end

    assign load = (state == exec_pkg::IDLE) && start;
    assign step = (state == exec_pkg::BUSY);
    // high from the cycle of presentation until entry to DONE
    assign busy = start && (state != exec_pkg::DONE);

    // uop stays presented while the datapath steps
    a_busy_while_stepping: assert property (@(posedge CLK) disable iff (!nRST)
        (state == exec_pkg::BUSY) |-> busy);

    // counter and FSM stay in lockstep
    a_last_to_done: assert property (@(posedge CLK) disable iff (!nRST)
        (state == exec_pkg::BUSY && last_step) |->
            $past(state == exec_pkg::BUSY, exec_pkg::MULDIV_STEPS - 1));

endmodule

`default_nettype wire

/* design/operand_alu.sv */
////////////////////////////////////////////////////////////
// Operand path and ALU. Applies memory-stage forwarding,
// sign-extends the I and S immediates, picks ALU ports
// by the select fields and computes the result.
// Purely combinational.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module operand_alu (
    input  exec_pkg::uop_t  ex_in,
    input  exec_pkg::fwd_t  fwd,
    output exec_pkg::word_t rs1_val,
    output exec_pkg::word_t rs2_val,
    output exec_pkg::word_t alu_out
);

    exec_pkg::word_t imm_i_ext;
    exec_pkg::word_t imm_s_ext;
    exec_pkg::word_t port_a;
    exec_pkg::word_t port_b;
    logic [4:0]      shamt;

    // memory stage result wins over register read
    assign rs1_val = fwd.fwd_rs1 ? fwd.rd_mem_data : ex_in.rs1_data;
    assign rs2_val = fwd.fwd_rs2 ? fwd.rd_mem_data : ex_in.rs2_data;

    assign imm_i_ext = {{20{ex_in.imm_i[11]}}, ex_in.imm_i};
    assign imm_s_ext = {{20{ex_in.imm_s[11]}}, ex_in.imm_s};

    always_comb begin
        case (ex_in.alu_a_sel)
            exec_pkg::A_RS1:   port_a = rs1_val;
            // store address base
            exec_pkg::A_IMM_S: port_a = imm_s_ext;
            // auipc
            exec_pkg::A_PC:    port_a = ex_in.pc;
            default:           port_a = '0;
        endcase
    end

    always_comb begin
        case (ex_in.alu_b_sel)
            exec_pkg::B_RS1:   port_b = rs1_val;
            exec_pkg::B_RS2:   port_b = rs2_val;
            // also carries shamt in its low bits
            exec_pkg::B_IMM_I: port_b = imm_i_ext;
            default:           port_b = ex_in.imm_u;
        endcase
    end

    assign shamt = port_b[4:0];

    always_comb begin
        case (ex_in.alu_op)
            exec_pkg::ADD:  alu_out = port_a + port_b;
            exec_pkg::SUB:  alu_out = port_a - port_b;
            exec_pkg::AND:  alu_out = port_a & port_b;
            exec_pkg::OR:   alu_out = port_a | port_b;
            exec_pkg::XOR:  alu_out = port_a ^ port_b;
            exec_pkg::SLL:  alu_out = port_a << shamt;
            exec_pkg::SRL:  alu_out = port_a >> shamt;
            exec_pkg::SRA:  alu_out = $signed(port_a) >>> shamt;
            exec_pkg::SLT:  alu_out = {31'b0, $signed(port_a) < $signed(port_b)};
            exec_pkg::SLTU: alu_out = {31'b0, port_a < port_b};
            default:        alu_out = '0;
        endcase
    end

endmodule

`default_nettype wire

/* execute_stage.f */
design/exec_pkg.sv
design/operand_alu.sv
design/branch_jump_unit.sv
design/muldiv_fsm.sv
design/muldiv_counter.sv
design/muldiv_datapath.sv
design/ex_mem_register.sv
design/execute_stage.sv
test/tb_execute_stage.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_execute_stage -f execute_stage.f \
    --Mdir "$BUILD_DIR" -o tb_execute_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_execute_stage" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0

/* test/tb_execute_stage.sv */
////////////////////////////////////////////////////////////
// Testbench for the execute stage. Plays the hazard unit,
// feeds random micro-ops from an LCG and compares the
// pipeline register and ex_busy against a local model.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage;

    localparam int N_UOPS = 400;
    localparam int CYCLE_LIMIT = N_UOPS * 40 + 100;
    localparam int HALF_PERIOD = 50;
    // presentation cycle plus one per iteration step
    localparam int MD_BUSY_CYCLES = exec_pkg::MULDIV_STEPS + 1;

    logic              CLK;
    logic              nRST;
    exec_pkg::uop_t    ex_in;
    exec_pkg::fwd_t    fwd;
    logic              ex_mem_stall;
    logic              ex_mem_flush;
    exec_pkg::ex_mem_t ex_mem;
    logic              ex_busy;

    logic [31:0] seed;
    int          errors;
    int          checks;
    int          cycles;

    execute_stage i_dut (
        .CLK, .nRST, .ex_in, .fwd, .ex_mem_stall, .ex_mem_flush, .ex_mem, .ex_busy
    );

    always #(HALF_PERIOD) CLK = !CLK;

    // hard stop if a handshake never completes
    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d checks done, %0d errors",
                     cycles, checks, errors);
            $display("Checks failed");
            $finish;
        end
    end

    // high half folded down since low LCG bits have short periods
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ {seed[15:0], seed[31:16]};
    endfunction

    function automatic logic [31:0] sign_extend(input logic [31:0] value, input int width);
        logic [31:0] mask;
        mask = 32'hffff_ffff << width;
        if (value[width-1]) begin
            return value | mask;
        end
        return value & ~mask;
    endfunction

    function automatic logic [31:0] alu_model(input exec_pkg::alu_op_t op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            exec_pkg::ADD:  return a + b;
            exec_pkg::SUB:  return a - b;
            exec_pkg::AND:  return a & b;
            exec_pkg::OR:   return a | b;
            exec_pkg::XOR:  return a ^ b;
            exec_pkg::SLL:  return a << sh;
            exec_pkg::SRL:  return a >> sh;
            exec_pkg::SRA:  return $signed(a) >>> sh;
            exec_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:        return 32'd0;
        endcase
    endfunction

    function automatic logic branch_model(input exec_pkg::branch_t kind,
                                          input logic [31:0] a, input logic [31:0] b);
        case (kind)
            exec_pkg::BEQ:  return a == b;
            exec_pkg::BNE:  return a != b;
            exec_pkg::BLT:  return $signed(a) < $signed(b);
            exec_pkg::BGE:  return $signed(a) >= $signed(b);
            exec_pkg::BLTU: return a < b;
            default:        return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] muldiv_model(input exec_pkg::muldiv_op_t op,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (op)
            exec_pkg::MUL:   return prod[31:0];
            exec_pkg::MULHU: return prod[63:32];
            // divide by zero gives all ones and the dividend as remainder
            exec_pkg::DIVU:  return (b == 32'd0) ? 32'hffff_ffff : a / b;
            default:         return (b == 32'd0) ? a : a % b;
        endcase
    endfunction

    // register contents after an edge that takes this uop
    function automatic exec_pkg::ex_mem_t expect_capture(input exec_pkg::uop_t u,
                                                         input exec_pkg::fwd_t f);
        exec_pkg::ex_mem_t e;
        logic [31:0]       rs1;
        logic [31:0]       rs2;
        logic [31:0]       pa;
        logic [31:0]       pb;
        logic              taken;
        rs1 = f.fwd_rs1 ? f.rd_mem_data : u.rs1_data;
        rs2 = f.fwd_rs2 ? f.rd_mem_data : u.rs2_data;
        case (u.alu_a_sel)
            exec_pkg::A_RS1:   pa = rs1;
            exec_pkg::A_IMM_S: pa = sign_extend(32'(u.imm_s), 12);
            exec_pkg::A_PC:    pa = u.pc;
            default:           pa = 32'd0;
        endcase
        case (u.alu_b_sel)
            exec_pkg::B_RS1:   pb = rs1;
            exec_pkg::B_RS2:   pb = rs2;
            exec_pkg::B_IMM_I: pb = sign_extend(32'(u.imm_i), 12);
            default:           pb = u.imm_u;
        endcase
        taken = u.branch && branch_model(u.branch_type, rs1, rs2);
        e = '0;
        if (u.jump && u.j_sel) begin
            e.brj_addr = u.pc + sign_extend(32'(u.imm_uj), 21);
        end else if (u.jump) begin
            e.brj_addr = rs1 + sign_extend(32'(u.imm_i), 12);
        end else if (taken) begin
            e.brj_addr = u.pc + sign_extend(32'(u.imm_sb), 13);
        end else begin
            e.brj_addr = u.pc + 32'(exec_pkg::PC_STEP);
        end
        e.valid = u.valid;
        e.illegal = u.illegal;
        // illegal uops lose their side effects
        e.reg_write = u.reg_write && !u.illegal;
        e.dren = u.dren && !u.illegal;
        e.dwen = u.dwen && !u.illegal;
        e.branch_taken = taken && !u.illegal;
        e.jump = u.jump && !u.illegal;
        e.rd = u.rd;
        if (u.muldiv_sel) begin
            e.result = muldiv_model(u.muldiv_op, rs1, rs2);
        end else begin
            e.result = alu_model(u.alu_op, pa, pb);
        end
        e.store_data = rs2;
        e.pc = u.pc;
        return e;
    endfunction

    task automatic make_uop(output exec_pkg::uop_t u, output exec_pkg::fwd_t f);
        logic [31:0] r;
        logic [31:0] w;
        r = next_rand();
        u = '0;
        u.valid = 1'b1;
        u.illegal = (r[3:0] == 4'd0);
        // about one in four is muldiv
        u.muldiv_sel = (r[5:4] == 2'd0);
        u.muldiv_op = exec_pkg::muldiv_op_t'(r[7:6]);
        u.alu_op = exec_pkg::alu_op_t'(4'(r[15:8] % 8'd10));
        u.alu_a_sel = exec_pkg::alu_a_sel_t'(r[17:16]);
        u.alu_b_sel = exec_pkg::alu_b_sel_t'(r[19:18]);
        u.branch = (r[21:20] == 2'd1);
        u.jump = (r[21:20] == 2'd2);
        u.j_sel = r[22];
        // unused codes 2 and 3 fold onto the unsigned pair
        if (r[25:24] == 2'b01) begin
            u.branch_type = exec_pkg::branch_t'({1'b1, r[24:23]});
        end else begin
            u.branch_type = exec_pkg::branch_t'(r[25:23]);
        end
        u.reg_write = r[26];
        u.dren = r[27];
        u.dwen = r[28];
        f.fwd_rs1 = r[29];
        f.fwd_rs2 = r[30];
        w = next_rand();
        u.rd = w[4:0];
        u.imm_i = w[16:5];
        u.imm_s = w[28:17];
        w = next_rand();
        u.imm_sb = {w[12:1], 1'b0};
        u.imm_uj = {w[31:12], 1'b0};
        w = next_rand();
        u.imm_u = {w[31:12], 12'b0};
        w = next_rand();
        u.pc = {w[31:2], 2'b00};
        u.rs1_data = next_rand();
        w = next_rand();
        // equal operands and zero divisors show up often
        u.rs2_data = r[31] ? w : (w[0] ? u.rs1_data : 32'd0);
        f.rd_mem_data = next_rand();
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_ex_mem(input exec_pkg::ex_mem_t e);
        compare_bit("ex_mem.valid", ex_mem.valid, e.valid);
        compare_bit("ex_mem.illegal", ex_mem.illegal, e.illegal);
        compare_bit("ex_mem.reg_write", ex_mem.reg_write, e.reg_write);
        compare_bit("ex_mem.dren", ex_mem.dren, e.dren);
        compare_bit("ex_mem.dwen", ex_mem.dwen, e.dwen);
        compare_bit("ex_mem.branch_taken", ex_mem.branch_taken, e.branch_taken);
        compare_bit("ex_mem.jump", ex_mem.jump, e.jump);
        compare_word("ex_mem.rd", 32'(ex_mem.rd), 32'(e.rd));
        compare_word("ex_mem.result", ex_mem.result, e.result);
        compare_word("ex_mem.store_data", ex_mem.store_data, e.store_data);
        compare_word("ex_mem.brj_addr", ex_mem.brj_addr, e.brj_addr);
        compare_word("ex_mem.pc", ex_mem.pc, e.pc);
    endtask

    initial begin
        exec_pkg::uop_t    cur;
        exec_pkg::fwd_t    cur_fwd;
        exec_pkg::ex_mem_t exp_mem;
        logic [31:0]       r;
        logic              need_new;
        logic              md_active;
        logic              busy_now;
        logic              stall;
        logic              flush;
        logic              done_all;
        int                issued;
        int                md_cycles;
        CLK = 1'b0;
        nRST = 1'b0;
        ex_in = '0;
        fwd = '0;
        ex_mem_stall = 1'b0;
        ex_mem_flush = 1'b0;
        seed = 32'h14c2_3f41;
        errors = 0;
        checks = 0;
        cycles = 0;
        cur = '0;
        cur_fwd = '0;
        exp_mem = '0;
        need_new = 1'b1;
        md_active = 1'b0;
        done_all = 1'b0;
        issued = 0;
        md_cycles = 0;
        repeat (5) @(negedge CLK);
        check_ex_mem(exp_mem);
        compare_bit("ex_busy", ex_busy, 1'b0);
        nRST = 1'b1;
        // the idle bubble is taken at the first edge out of reset
        exp_mem = expect_capture(ex_in, fwd);

        while (!done_all) begin
            @(negedge CLK);
            // register value taken at the last rising edge
            check_ex_mem(exp_mem);
            busy_now = ex_busy;
            if (md_active && busy_now) begin
                md_cycles++;
            end else if (md_active) begin
                compare_word("ex_busy cycles", 32'(md_cycles), 32'(MD_BUSY_CYCLES));
                md_active = 1'b0;
            end
            if (need_new && issued == N_UOPS) begin
                done_all = 1'b1;
            end else begin
                if (need_new) begin
                    make_uop(cur, cur_fwd);
                    issued++;
                    md_active = cur.muldiv_sel;
                    md_cycles = 1;
                end
                r = next_rand();
                // hazard unit holds stall with busy and adds random bubbles
                if (cur.muldiv_sel && (need_new || busy_now)) begin
                    stall = 1'b1;
                    flush = 1'b0;
                end else begin
                    stall = (r[2:0] == 3'd0);
                    flush = (r[6:3] == 4'd0);
                end
                if (!stall && flush) begin
                    exp_mem = '0;
                end else if (!stall) begin
                    exp_mem = expect_capture(cur, cur_fwd);
                end
                ex_in = cur;
                fwd = cur_fwd;
                ex_mem_stall = stall;
                ex_mem_flush = flush;
                if (need_new) begin
                    // busy answers within the presentation cycle
                    #(HALF_PERIOD / 2);
                    compare_bit("ex_busy", ex_busy, cur.muldiv_sel);
                end
                // uop leaves only on an edge that advances
                need_new = !stall && !flush;
            end
        end

        $display("%0d uops, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
